//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	localparam int line_words = 4; // words per cache line, also the beats of a fill burst
	localparam int word_sel_bits = $clog2(line_words);
	localparam int offset_bits = word_sel_bits + 2; // byte offset inside one line

	typedef logic [3:0] burst_len_t; // number of beats minus one
	typedef logic [1:0] burst_kind_t;

	localparam burst_kind_t burst_fixed = 2'b00;
	localparam burst_kind_t burst_incr = 2'b01;

	typedef struct packed {
		addr_t address;
		burst_kind_t kind;
		burst_len_t length;
	} bus_req_t;

	// one returned beat together with the address it was read from
	typedef struct packed {
		addr_t address;
		word_t data;
	} beat_t;

	typedef struct packed {
		addr_t pc;
		word_t inst;
	} fetch_out_t;

	typedef enum logic [2:0] {
		issue,
		lookup,
		fill_wait,
		uncached_wait,
		deliver
	} fetch_state_e;

endpackage

`default_nettype wire

//--- design/burst_reader.sv
`timescale 1ns/100ps
`default_nettype none

module burst_reader (
	input wire clock,
	input wire reset,
	input wire rd_start,
	input wire fetch_pkg::bus_req_t rd_req,
	output fetch_pkg::bus_req_t bus_ar,
	output logic ar_valid,
	input wire ar_ready,
	input wire fetch_pkg::word_t r_data,
	input wire r_valid,
	input wire r_last,
	output logic beat_valid,
	output fetch_pkg::beat_t rd_beat,
	output logic rd_done
);

	logic busy; // high from rd_start until the last beat has come back
	fetch_pkg::burst_len_t beat_count;
	fetch_pkg::addr_t beat_offset;

	// a fixed burst reads the same address on every beat
	assign beat_offset = (bus_ar.kind == fetch_pkg::burst_incr) ?
		fetch_pkg::addr_t'({beat_count, 2'b00}) : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			ar_valid <= 1'b0;
			beat_count <= '0;
			beat_valid <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			beat_valid <= 1'b0;
			rd_done <= 1'b0;
			if (rd_start) begin
				busy <= 1'b1;
				ar_valid <= 1'b1;
				beat_count <= '0;
			end else if (ar_valid && ar_ready) begin
				ar_valid <= 1'b0; // request accepted, now only data is awaited
			end
			if (busy && r_valid) begin
				beat_valid <= 1'b1;
				rd_done <= r_last;
				beat_count <= beat_count + 1'b1;
				if (r_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_start) begin
			bus_ar <= rd_req;
		end
		if (busy && r_valid) begin
			rd_beat.address <= bus_ar.address + beat_offset;
			rd_beat.data <= r_data;
		end
	end

	// the memory ends the burst exactly on the beat the request length announced
	last_beat_matches_length: assert property (@(posedge clock) disable iff (reset)
		busy && r_valid |-> (r_last == (beat_count == bus_ar.length)));

	// the fetch unit keeps only one read outstanding
	no_start_while_busy: assert property (@(posedge clock) disable iff (reset)
		rd_start |-> !busy);

endmodule

`default_nettype wire

//--- design/inst_cache.sv
`timescale 1ns/100ps
`default_nettype none

module inst_cache #(
	parameter int cache_lines = 16
) (
	input wire clock,
	input wire reset,
	input wire lookup,
	input wire fetch_pkg::addr_t lookup_addr,
	output logic hit,
	output fetch_pkg::word_t hit_data,
	input wire beat_valid,
	input wire fetch_pkg::beat_t rd_beat,
	input wire rd_done
);

	localparam int addr_bits = $bits(fetch_pkg::addr_t);
	localparam int index_bits = $clog2(cache_lines);
	localparam int tag_bits = addr_bits - index_bits - fetch_pkg::offset_bits;

	typedef logic [index_bits-1:0] index_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [fetch_pkg::word_sel_bits-1:0] word_sel_t;

	fetch_pkg::word_t data_mem [cache_lines][fetch_pkg::line_words];
	tag_t tag_mem [cache_lines];
	logic [cache_lines-1:0] line_valid;

	index_t lookup_index;
	tag_t lookup_tag;
	word_sel_t lookup_word;
	logic lookup_match;

	logic fill_pending; // a miss has opened a fill that rd_done will close
	index_t fill_index;
	tag_t fill_tag;
	word_sel_t beat_word;

	assign lookup_index = lookup_addr[fetch_pkg::offset_bits +: index_bits];
	assign lookup_tag = lookup_addr[addr_bits-1 -: tag_bits];
	assign lookup_word = lookup_addr[2 +: fetch_pkg::word_sel_bits];
	assign lookup_match = line_valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	assign beat_word = rd_beat.address[2 +: fetch_pkg::word_sel_bits];

	always_ff @(posedge clock) begin
		if (reset) begin
			hit <= 1'b0;
			fill_pending <= 1'b0;
			line_valid <= '0;
		end else begin
			hit <= lookup && lookup_match;
			if (lookup && !lookup_match) begin
				fill_pending <= 1'b1;
				line_valid[lookup_index] <= 1'b0; // old contents get overwritten beat by beat
			end
			if (fill_pending && rd_done) begin
				fill_pending <= 1'b0;
				line_valid[fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookup) begin
			hit_data <= data_mem[lookup_index][lookup_word];
		end
		if (lookup && !lookup_match) begin
			fill_index <= lookup_index;
			fill_tag <= lookup_tag;
		end
		if (fill_pending && beat_valid) begin
			data_mem[fill_index][beat_word] <= rd_beat.data;
		end
		if (fill_pending && rd_done) begin
			tag_mem[fill_index] <= fill_tag;
		end
	end

	// every beat of a fill belongs to the line that missed
	beat_in_pending_line: assert property (@(posedge clock) disable iff (reset)
		fill_pending && beat_valid |->
			rd_beat.address[addr_bits-1:fetch_pkg::offset_bits] == {fill_tag, fill_index});

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter fetch_pkg::addr_t reset_pc = 32'h3000_0000,
	parameter fetch_pkg::addr_t cache_base = 32'ha000_0000,
	parameter fetch_pkg::addr_t cache_limit = 32'ha200_0000
) (
	input wire clock,
	input wire reset,
	output logic lookup,
	output fetch_pkg::addr_t lookup_addr,
	input wire hit,
	input wire fetch_pkg::word_t hit_data,
	output logic rd_start,
	output fetch_pkg::bus_req_t rd_req,
	input wire beat_valid,
	input wire fetch_pkg::beat_t rd_beat,
	input wire rd_done,
	output fetch_pkg::fetch_out_t fetch_out,
	output logic inst_valid,
	input wire inst_ready,
	input wire redirect,
	input wire fetch_pkg::addr_t redirect_pc
);

	localparam int addr_bits = $bits(fetch_pkg::addr_t);

	fetch_pkg::fetch_state_e state;
	fetch_pkg::addr_t pc;
	fetch_pkg::addr_t line_addr;
	logic cacheable;
	logic redirect_pending; // a redirect came while a fetch was in flight
	fetch_pkg::addr_t redirect_target;
	logic restart;
	fetch_pkg::addr_t restart_pc;

	assign cacheable = (pc >= cache_base) && (pc < cache_limit);
	assign line_addr = {pc[addr_bits-1:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};

	// a redirect in the same cycle wins over the saved one
	assign restart = redirect || redirect_pending;
	assign restart_pc = redirect ? redirect_pc : redirect_target;

	assign lookup = (state == fetch_pkg::issue) && cacheable;
	assign lookup_addr = pc;
	assign rd_start = ((state == fetch_pkg::issue) && !cacheable) ||
		((state == fetch_pkg::lookup) && !hit);

	always_comb begin
		if (cacheable) begin
			rd_req.address = line_addr;
			rd_req.kind = fetch_pkg::burst_incr;
			rd_req.length = fetch_pkg::burst_len_t'(fetch_pkg::line_words - 1);
		end else begin
			rd_req.address = pc;
			rd_req.kind = fetch_pkg::burst_fixed;
			rd_req.length = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::deliver; // nothing is held, so the first cycle goes on to issue
			pc <= reset_pc;
			inst_valid <= 1'b0;
			redirect_pending <= 1'b0;
		end else begin
			if (redirect) begin
				redirect_pending <= 1'b1;
			end
			case (state)
				fetch_pkg::issue: begin
					state <= cacheable ? fetch_pkg::lookup : fetch_pkg::uncached_wait;
				end
				fetch_pkg::lookup: begin
					if (!hit) begin
						state <= fetch_pkg::fill_wait; // the line is filled even if it gets dropped
					end else if (restart) begin
						pc <= restart_pc;
						redirect_pending <= 1'b0;
						state <= fetch_pkg::issue;
					end else begin
						inst_valid <= 1'b1;
						state <= fetch_pkg::deliver;
					end
				end
				fetch_pkg::fill_wait, fetch_pkg::uncached_wait: begin
					if (rd_done && restart) begin
						pc <= restart_pc;
						redirect_pending <= 1'b0;
						state <= fetch_pkg::issue;
					end else if (rd_done) begin
						inst_valid <= 1'b1;
						state <= fetch_pkg::deliver;
					end
				end
				fetch_pkg::deliver: begin
					if (redirect) begin
						pc <= redirect_pc; // the held word is discarded
						inst_valid <= 1'b0;
						redirect_pending <= 1'b0;
						state <= fetch_pkg::issue;
					end else if (!inst_valid) begin
						state <= fetch_pkg::issue;
					end else if (inst_ready) begin
						pc <= pc + 32'd4;
						inst_valid <= 1'b0;
						state <= fetch_pkg::issue;
					end
				end
				default: begin
					state <= fetch_pkg::issue;
				end
			endcase
		end
	end

	// fetch_out only changes while inst_valid is low
	always_ff @(posedge clock) begin
		if (redirect) begin
			redirect_target <= redirect_pc;
		end
		case (state)
			fetch_pkg::issue: begin
				fetch_out.pc <= pc;
			end
			fetch_pkg::lookup: begin
				if (hit) begin
					fetch_out.inst <= hit_data;
				end
			end
			fetch_pkg::fill_wait: begin
				if (beat_valid && (rd_beat.address == pc)) begin
					fetch_out.inst <= rd_beat.data; // the requested word out of the line
				end
			end
			fetch_pkg::uncached_wait: begin
				if (beat_valid) begin
					fetch_out.inst <= rd_beat.data;
				end
			end
			default: begin
			end
		endcase
	end

	// a word held under back-pressure stays put until taken or discarded
	held_word_stable: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(fetch_out));

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
	parameter fetch_pkg::addr_t reset_pc = 32'h3000_0000,
	parameter fetch_pkg::addr_t cache_base = 32'ha000_0000,
	parameter fetch_pkg::addr_t cache_limit = 32'ha200_0000,
	parameter int cache_lines = 16
) (
	input wire clock,
	input wire reset,
	output wire fetch_pkg::bus_req_t bus_ar,
	output wire ar_valid,
	input wire ar_ready,
	input wire fetch_pkg::word_t r_data,
	input wire r_valid,
	input wire r_last,
	output wire fetch_pkg::fetch_out_t fetch_out,
	output wire inst_valid,
	input wire inst_ready,
	input wire redirect,
	input wire fetch_pkg::addr_t redirect_pc
);

	wire lookup;
	wire fetch_pkg::addr_t lookup_addr;
	wire hit;
	wire fetch_pkg::word_t hit_data;
	wire rd_start;
	wire fetch_pkg::bus_req_t rd_req;
	wire beat_valid;
	wire fetch_pkg::beat_t rd_beat; // shared by the cache fill and the fetch unit
	wire rd_done;

	burst_reader reader (
		.clock(clock),
		.reset(reset),
		.rd_start(rd_start),
		.rd_req(rd_req),
		.bus_ar(bus_ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r_data(r_data),
		.r_valid(r_valid),
		.r_last(r_last),
		.beat_valid(beat_valid),
		.rd_beat(rd_beat),
		.rd_done(rd_done)
	);

	inst_cache #(
		.cache_lines(cache_lines)
	) cache (
		.clock(clock),
		.reset(reset),
		.lookup(lookup),
		.lookup_addr(lookup_addr),
		.hit(hit),
		.hit_data(hit_data),
		.beat_valid(beat_valid),
		.rd_beat(rd_beat),
		.rd_done(rd_done)
	);

	fetch_unit #(
		.reset_pc(reset_pc),
		.cache_base(cache_base),
		.cache_limit(cache_limit)
	) fetch (
		.clock(clock),
		.reset(reset),
		.lookup(lookup),
		.lookup_addr(lookup_addr),
		.hit(hit),
		.hit_data(hit_data),
		.rd_start(rd_start),
		.rd_req(rd_req),
		.beat_valid(beat_valid),
		.rd_beat(rd_beat),
		.rd_done(rd_done),
		.fetch_out(fetch_out),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

endmodule

`default_nettype wire

//--- tb/bus_memory.sv
`timescale 1ns/100ps
`default_nettype none

module bus_memory #(
	parameter int seed_init = 24059
) (
	input wire clock,
	input wire reset,
	input wire fetch_pkg::bus_req_t bus_ar,
	input wire ar_valid,
	output logic ar_ready,
	output fetch_pkg::word_t r_data,
	output logic r_valid,
	output logic r_last
);

	localparam fetch_pkg::word_t data_key = 32'h5a5a_5a5a;

	integer seed;
	fetch_pkg::bus_req_t req;
	fetch_pkg::addr_t beat_addr;

	task automatic wait_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			#1;
		end
	endtask

	// one request at a time, each answered after a random delay
	initial begin
		seed = seed_init;
		ar_ready = 1'b0;
		r_data = '0;
		r_valid = 1'b0;
		r_last = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			if (!reset && ar_valid) begin
				wait_cycles($random(seed) & 3);
				ar_ready = 1'b1;
				req = bus_ar; // held steady by the reader until accepted
				wait_cycles(1);
				ar_ready = 1'b0;
				for (int beat = 0; beat <= int'(req.length); beat++) begin
					wait_cycles($random(seed) & 3);
					beat_addr = (req.kind == fetch_pkg::burst_incr) ?
						req.address + 32'(beat * 4) : req.address;
					r_data = beat_addr ^ data_key;
					r_valid = 1'b1;
					r_last = (beat == int'(req.length));
					wait_cycles(1);
					r_valid = 1'b0;
					r_last = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

	localparam fetch_pkg::addr_t reset_pc = 32'h3000_0000;
	localparam fetch_pkg::addr_t cache_base = 32'ha000_0000;
	localparam fetch_pkg::addr_t cache_limit = 32'ha200_0000;
	localparam int cache_lines = 16;
	localparam int seed_value = 24059;
	localparam fetch_pkg::word_t data_key = 32'h5a5a_5a5a;
	localparam int clock_period = 20;
	localparam int test_words = 8 + 64 + 64 + 12 + 24; // redirects count as one fetch each
	localparam int worst_fetch_cycles = 64; // slowest miss plus a long decoder stall
	localparam fetch_pkg::addr_t line_a = 32'ha000_0100;
	localparam fetch_pkg::addr_t line_b = 32'ha100_0040;
	localparam fetch_pkg::addr_t uncached_c = 32'h3000_1000;

	logic clock;
	logic reset;
	wire fetch_pkg::bus_req_t bus_ar;
	wire ar_valid;
	wire ar_ready;
	wire fetch_pkg::word_t r_data;
	wire r_valid;
	wire r_last;
	wire fetch_pkg::fetch_out_t fetch_out;
	wire inst_valid;
	logic inst_ready;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;

	integer seed = seed_value;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int errors_at_start;
	int window_requests;
	fetch_pkg::addr_t window_lo;
	fetch_pkg::addr_t window_hi;
	fetch_pkg::addr_t expect_pc;
	fetch_pkg::addr_t pc_one_back; // expected pc before the previous edge
	logic hold_seen;
	logic ar_valid_last;
	fetch_pkg::fetch_out_t held_out;

	fetch_top #(
		.reset_pc(reset_pc),
		.cache_base(cache_base),
		.cache_limit(cache_limit),
		.cache_lines(cache_lines)
	) dut (
		.clock(clock),
		.reset(reset),
		.bus_ar(bus_ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r_data(r_data),
		.r_valid(r_valid),
		.r_last(r_last),
		.fetch_out(fetch_out),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	bus_memory #(
		.seed_init(seed_value)
	) memory (
		.clock(clock),
		.reset(reset),
		.bus_ar(bus_ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r_data(r_data),
		.r_valid(r_valid),
		.r_last(r_last)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		#1;
		inst_ready = ($random(seed) & 1) != 0; // decoder stalls about half the time
	end

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s: expected %h, got %h at %0t", name, expected, actual, $time);
		error_count++;
	endtask

	task automatic check_request(input fetch_pkg::addr_t issue_pc);
		if (bus_ar.address >= cache_base && bus_ar.address < cache_limit) begin
			assert (bus_ar.kind == fetch_pkg::burst_incr)
				else report_value("bus_ar.kind", 32'(fetch_pkg::burst_incr), 32'(bus_ar.kind));
			assert (bus_ar.length == 4'd3) else report_value("bus_ar.length", 32'd3, 32'(bus_ar.length));
			assert (bus_ar.address[3:0] == 4'h0)
				else report_value("bus_ar.address", {bus_ar.address[31:4], 4'h0}, bus_ar.address);
		end else begin
			assert (bus_ar.kind == fetch_pkg::burst_fixed)
				else report_value("bus_ar.kind", 32'(fetch_pkg::burst_fixed), 32'(bus_ar.kind));
			assert (bus_ar.length == 4'd0) else report_value("bus_ar.length", 32'd0, 32'(bus_ar.length));
			assert (bus_ar.address == issue_pc) else report_value("bus_ar.address", issue_pc, bus_ar.address);
		end
		if (bus_ar.address >= window_lo && bus_ar.address < window_hi) begin
			window_requests++;
		end
	endtask

	// values read here are the ones from before the edge
	always @(posedge clock) begin
		if (reset) begin
			expect_pc = reset_pc;
			pc_one_back = reset_pc;
			hold_seen = 1'b0;
			ar_valid_last = 1'b0;
		end else begin
			if (hold_seen) begin
				assert (inst_valid) else report_value("inst_valid", 32'd1, 32'(inst_valid));
				assert (fetch_out.pc == held_out.pc) else report_value("fetch_out.pc", held_out.pc, fetch_out.pc);
				assert (fetch_out.inst == held_out.inst)
					else report_value("fetch_out.inst", held_out.inst, fetch_out.inst);
			end
			hold_seen = inst_valid && !inst_ready && !redirect;
			held_out = fetch_out;
			if (ar_valid && !ar_valid_last) begin
				check_request(pc_one_back); // an uncached read was issued one edge earlier
			end
			ar_valid_last = ar_valid;
			pc_one_back = expect_pc;
			if (redirect) begin
				expect_pc = redirect_pc; // a held word is dropped, not transferred
			end else if (inst_valid && inst_ready) begin
				assert (fetch_out.pc == expect_pc) else report_value("fetch_out.pc", expect_pc, fetch_out.pc);
				assert (fetch_out.inst == (expect_pc ^ data_key))
					else report_value("fetch_out.inst", expect_pc ^ data_key, fetch_out.inst);
				expect_pc = expect_pc + 32'd4;
			end
		end
	end

	task automatic redirect_to(input fetch_pkg::addr_t target);
		redirect = 1'b1;
		redirect_pc = target;
		@(posedge clock);
		#1;
		redirect = 1'b0;
	endtask

	// returns while the word at stop_pc is held for the decoder
	task automatic run_until_pc(input fetch_pkg::addr_t stop_pc);
		while (!(inst_valid && fetch_out.pc == stop_pc)) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic count_window(input fetch_pkg::addr_t lo, input fetch_pkg::addr_t hi);
		window_lo = lo;
		window_hi = hi;
		window_requests = 0;
	endtask

	task automatic expect_requests(input int expected);
		assert (window_requests == expected) else begin
			$display("bus requests for the watched lines: expected %0d, saw %0d",
				expected, window_requests);
			error_count++;
		end
	endtask

	task automatic open_test();
		errors_at_start = error_count;
	endtask

	task automatic close_test(input string name);
		if (error_count == errors_at_start) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, error_count - errors_at_start);
		end
	endtask

	initial begin
		fetch_pkg::addr_t target;

		reset = 1'b1;
		inst_ready = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		count_window('0, '0);
		repeat (16) @(posedge clock);
		#1;
		open_test();
		assert (!ar_valid) else report_value("ar_valid", 32'd0, 32'(ar_valid));
		assert (!inst_valid) else report_value("inst_valid", 32'd0, 32'(inst_valid));
		reset = 1'b0;
		run_until_pc(reset_pc + 32'h1c);
		close_test("reset_and_uncached");

		open_test();
		count_window(line_a, line_a + 32'h100);
		redirect_to(line_a);
		run_until_pc(line_a + 32'hfc); // the last word is dropped by the next redirect
		expect_requests(16);
		close_test("cache_fill");

		open_test();
		count_window(line_a, line_a + 32'h100);
		redirect_to(line_a);
		run_until_pc(line_a + 32'hfc);
		expect_requests(0);
		close_test("cache_reuse");

		open_test();
		redirect_to(line_b);
		while (!ar_valid) begin
			@(posedge clock);
			#1;
		end
		redirect_to(uncached_c); // lands while the line fill is pending
		run_until_pc(uncached_c + 32'h10);
		count_window(line_b, line_b + 32'h10);
		redirect_to(line_b);
		run_until_pc(line_b + 32'hc);
		expect_requests(0);
		close_test("redirect_during_burst");

		open_test();
		for (int i = 0; i < 20; i++) begin
			wait_cycles(1 + i % 7);
			target = (i % 2 == 0) ? cache_base + 32'(i * 32'h234) : 32'h3000_4000 + 32'(i * 12);
			redirect_to(target);
		end
		run_until_pc(target + 32'h8);
		close_test("redirect_sequence");

		$display("tests: %0d passed, %0d failed, %0d check errors",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(test_words * worst_fetch_cycles * clock_period);
		$display("watchdog: the tests did not finish within %0d cycles",
			test_words * worst_fetch_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
design/fetch_pkg.sv
design/burst_reader.sv
design/inst_cache.sv
design/fetch_unit.sv
design/fetch_top.sv
tb/bus_memory.sv
tb/tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
# builds the fetch stage testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fetch -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
